/* hw/cpu_pkg.sv */
// -------------------------------------------------
// shared widths, encodings and bundles of the core
// word accesses only; the bus carries word addresses
// unknown opcodes and functions decode as no-ops
// -------------------------------------------------

package cpu_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_ORI     = 6'h0d,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// function field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} alu_op_e;

	// -------------------------------------------------
	// bus bundles
	// -------------------------------------------------
	typedef struct packed {
		logic [XLEN-3:0] adr;
		logic [XLEN-1:0] wdata;
		logic            we;
		logic            stb;
	} bus_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;
		logic            ack;
	} bus_rsp_t;

	// -------------------------------------------------
	// pipeline bundles
	// -------------------------------------------------
	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    mem_read;
		logic    mem_write;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    reg_write;
	} ctrl_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [XLEN-1:0]       rs_data;
		logic [XLEN-1:0]       rt_data;
		logic [XLEN-1:0]       imm;
		logic [25:0]           jidx;
		logic [REG_ADDR_W-1:0] dest;
		ctrl_t                 ctrl;
	} id_ex_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       store_data;
		logic [REG_ADDR_W-1:0] dest;
		logic                  mem_read;
		logic                  mem_write;
		logic                  reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic                  en;
		logic [REG_ADDR_W-1:0] dest;
		logic [XLEN-1:0]       data;
	} wb_t;

endpackage

/* hw/cpu_fetch.sv */
// -------------------------------------------------
// PC and instruction read, one word per request
// fetch starts one clock after reset is released
// a word acked during a stall is held until release
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_fetch (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     stall_i,
	output cpu_pkg::bus_req_t        inst_req_o,
	input  cpu_pkg::bus_rsp_t        inst_rsp_i,
	input  logic                     redirect_i,
	input  logic [cpu_pkg::XLEN-1:0] target_i,
	output logic [31:0]              instr_o,
	output logic [cpu_pkg::XLEN-1:0] pc_o,
	output logic                     valid_o
);
	import cpu_pkg::*;

	logic            run_q;
	logic            done_q;
	logic            valid_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] if_pc_q;
	logic [31:0]     hold_q;
	logic [31:0]     if_instr_q;
	logic [31:0]     fetched;

	assign inst_req_o.adr   = pc_q[XLEN-1:2];
	assign inst_req_o.wdata = '0;
	assign inst_req_o.we    = 1'b0;
	assign inst_req_o.stb   = run_q & ~done_q;

	assign fetched = done_q ? hold_q : inst_rsp_i.rdata;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			run_q   <= 1'b0;
			done_q  <= 1'b0;
			valid_q <= 1'b0;
			pc_q    <= RESET_PC;
		end else begin
			run_q <= 1'b1;
			if (!stall_i) begin
				done_q  <= 1'b0;
				// word fetched while a redirect is pending is squashed
				valid_q <= run_q & ~redirect_i;
				if (run_q)
					pc_q <= redirect_i ? target_i : pc_q + XLEN'(4);
			end else if (inst_req_o.stb && inst_rsp_i.ack) begin
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inst_req_o.stb && inst_rsp_i.ack)
			hold_q <= inst_rsp_i.rdata;
		if (!stall_i) begin
			if_instr_q <= fetched;
			if_pc_q    <= pc_q;
		end
	end

	// word in decode behind the delay slot is dropped too
	assign valid_o = valid_q & ~redirect_i;
	assign instr_o = if_instr_q;
	assign pc_o    = if_pc_q;

endmodule

/* hw/cpu_decode.sv */
// -------------------------------------------------
// instruction decoder and ID/EX register
// unknown opcodes and functions leave a no-op
// register operands are read here, same cycle
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_decode (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           stall_i,
	input  logic [31:0]                    instr_i,
	input  logic [cpu_pkg::XLEN-1:0]       pc_i,
	input  logic                           valid_i,
	input  logic [cpu_pkg::XLEN-1:0]       rs_data_i,
	input  logic [cpu_pkg::XLEN-1:0]       rt_data_i,
	output logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr_o,
	output logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr_o,
	output cpu_pkg::id_ex_t                id_ex_o
);
	import cpu_pkg::*;

	opcode_e               opcode;
	funct_e                funct;
	ctrl_t                 ctrl;
	logic                  sign_ext;
	logic [REG_ADDR_W-1:0] dest;
	id_ex_t                id_ex_d;
	id_ex_t                id_ex_q;

	assign opcode    = opcode_e'(instr_i[31:26]);
	assign funct     = funct_e'(instr_i[5:0]);
	assign rs_addr_o = instr_i[25:21];
	assign rt_addr_o = instr_i[20:16];

	always_comb begin
		ctrl     = '0;
		sign_ext = 1'b1;
		dest     = instr_i[20:16];
		case (opcode)
			OP_SPECIAL: begin
				dest           = instr_i[15:11];
				ctrl.reg_write = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op    = ALU_OR;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				sign_ext       = 1'b0;
			end
			OP_LUI: begin
				ctrl.alu_op    = ALU_LUI;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				sign_ext       = 1'b0;
			end
			OP_LW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_SW: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			OP_BEQ: ctrl.branch_eq = 1'b1;
			OP_BNE: ctrl.branch_ne = 1'b1;
			OP_J:   ctrl.jump      = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		id_ex_d.valid   = valid_i;
		id_ex_d.pc      = pc_i;
		id_ex_d.rs      = instr_i[25:21];
		id_ex_d.rt      = instr_i[20:16];
		id_ex_d.rs_data = rs_data_i;
		id_ex_d.rt_data = rt_data_i;
		id_ex_d.imm     = sign_ext ? {{(XLEN-16){instr_i[15]}}, instr_i[15:0]}
			: {{(XLEN-16){1'b0}}, instr_i[15:0]};
		id_ex_d.jidx    = instr_i[25:0];
		id_ex_d.dest    = dest;
		id_ex_d.ctrl    = ctrl;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			id_ex_q <= '0;
		else if (!stall_i)
			id_ex_q <= id_ex_d;
	end

	assign id_ex_o = id_ex_q;

endmodule

/* hw/cpu_gpr.sv */
// -------------------------------------------------
// 32 x 32 register file, two read ports, one write
// register zero always reads zero
// a write in progress is seen by a same-cycle read
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_gpr (
	input  logic                           clk,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] rs_addr_i,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] rt_addr_i,
	output logic [cpu_pkg::XLEN-1:0]       rs_data_o,
	output logic [cpu_pkg::XLEN-1:0]       rt_data_o,
	input  cpu_pkg::wb_t                   wb_i,
	input  logic                           stall_i
);
	import cpu_pkg::*;

	logic [XLEN-1:0] regs [31:1];

	function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb_i.en && wb_i.dest == addr)
			return wb_i.data;
		return regs[addr];
	endfunction

	always_comb begin
		rs_data_o = read_port(rs_addr_i);
		rt_data_o = read_port(rt_addr_i);
	end

	always_ff @(posedge clk) begin
		if (wb_i.en && !stall_i && wb_i.dest != '0)
			regs[wb_i.dest] <= wb_i.data;
	end

endmodule

/* hw/cpu_execute.sv */
// -------------------------------------------------
// operand forwarding, ALU, branch resolution and
// the EX/MEM register
// taken redirect is registered, one delay slot
// a load result is not forwarded from this stage
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_execute (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     stall_i,
	input  cpu_pkg::id_ex_t          id_ex_i,
	input  cpu_pkg::wb_t             mem_fwd_i,
	output cpu_pkg::ex_mem_t         ex_mem_o,
	output logic                     redirect_o,
	output logic [cpu_pkg::XLEN-1:0] target_o
);
	import cpu_pkg::*;

	ex_mem_t         ex_mem_d;
	ex_mem_t         ex_mem_q;
	logic            redirect_q;
	logic [XLEN-1:0] target_q;
	logic [XLEN-1:0] rs_val;
	logic [XLEN-1:0] rt_val;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] next_target;
	logic            equal;
	logic            taken;

	// newest producer first, then writeback, then register file
	function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] idx,
		input logic [XLEN-1:0] rf_data);
		if (idx == '0)
			return rf_data;
		if (ex_mem_q.valid && ex_mem_q.reg_write && ex_mem_q.dest == idx)
			return ex_mem_q.result;
		if (mem_fwd_i.en && mem_fwd_i.dest == idx)
			return mem_fwd_i.data;
		return rf_data;
	endfunction

	// -------------------------------------------------
	// ALU
	// -------------------------------------------------
	always_comb begin
		rs_val = forward(id_ex_i.rs, id_ex_i.rs_data);
		rt_val = forward(id_ex_i.rt, id_ex_i.rt_data);
		op_b   = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rt_val;
		case (id_ex_i.ctrl.alu_op)
			ALU_ADD: alu_res = rs_val + op_b;
			ALU_SUB: alu_res = rs_val - op_b;
			ALU_AND: alu_res = rs_val & op_b;
			ALU_OR:  alu_res = rs_val | op_b;
			ALU_XOR: alu_res = rs_val ^ op_b;
			ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
			ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
			default: alu_res = '0;
		endcase
	end

	// -------------------------------------------------
	// branch and jump
	// -------------------------------------------------
	assign pc_plus4 = id_ex_i.pc + XLEN'(4);
	assign equal    = (rs_val == rt_val);
	assign taken    = id_ex_i.valid & (id_ex_i.ctrl.jump
		| (id_ex_i.ctrl.branch_eq & equal)
		| (id_ex_i.ctrl.branch_ne & ~equal));
	assign next_target = id_ex_i.ctrl.jump
		? {pc_plus4[XLEN-1:28], id_ex_i.jidx, 2'b00}
		: pc_plus4 + {id_ex_i.imm[XLEN-3:0], 2'b00};

	always_comb begin
		ex_mem_d.valid      = id_ex_i.valid;
		ex_mem_d.result     = alu_res;
		ex_mem_d.store_data = rt_val;
		ex_mem_d.dest       = id_ex_i.dest;
		ex_mem_d.mem_read   = id_ex_i.ctrl.mem_read;
		ex_mem_d.mem_write  = id_ex_i.ctrl.mem_write;
		ex_mem_d.reg_write  = id_ex_i.ctrl.reg_write;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ex_mem_q   <= '0;
			redirect_q <= 1'b0;
		end else if (!stall_i) begin
			ex_mem_q   <= ex_mem_d;
			redirect_q <= taken;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_i)
			target_q <= next_target;
	end

	assign ex_mem_o   = ex_mem_q;
	assign redirect_o = redirect_q;
	assign target_o   = target_q;

endmodule

/* hw/cpu_mem_stage.sv */
// -------------------------------------------------
// data-bus access and MEM/WB register
// word loads and stores only, address bits 1:0 unused
// an access acked during a stall is not repeated
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_mem_stage (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall_i,
	input  cpu_pkg::ex_mem_t  ex_mem_i,
	output cpu_pkg::bus_req_t data_req_o,
	input  cpu_pkg::bus_rsp_t data_rsp_i,
	output cpu_pkg::wb_t      wb_o
);
	import cpu_pkg::*;

	logic            access;
	logic            done_q;
	logic [XLEN-1:0] hold_q;
	logic [XLEN-1:0] load_data;
	wb_t             wb_q;

	assign access = ex_mem_i.valid & (ex_mem_i.mem_read | ex_mem_i.mem_write);

	assign data_req_o.adr   = ex_mem_i.result[XLEN-1:2];
	assign data_req_o.wdata = ex_mem_i.store_data;
	assign data_req_o.we    = ex_mem_i.mem_write;
	assign data_req_o.stb   = access & ~done_q;

	assign load_data = done_q ? hold_q : data_rsp_i.rdata;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			done_q <= 1'b0;
			wb_q   <= '0;
		end else if (!stall_i) begin
			done_q    <= 1'b0;
			wb_q.en   <= ex_mem_i.valid & ex_mem_i.reg_write;
			wb_q.dest <= ex_mem_i.dest;
			wb_q.data <= ex_mem_i.mem_read ? load_data : ex_mem_i.result;
		end else if (data_req_o.stb && data_rsp_i.ack) begin
			done_q <= 1'b1;
		end
	end

	// read data kept while another request holds the pipeline
	always_ff @(posedge clk) begin
		if (data_req_o.stb && data_rsp_i.ack)
			hold_q <= data_rsp_i.rdata;
	end

	assign wb_o = wb_q;

endmodule

/* hw/cpu_core.sv */
// -------------------------------------------------
// five-stage pipeline top: fetch, decode, execute,
// memory and writeback with one branch delay slot
// a request waiting for ack or pause_i freezes all
// the instruction after LW must not read its target
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_core (
	input  logic              clk,
	input  logic              reset,
	output cpu_pkg::bus_req_t inst_req_o,
	input  cpu_pkg::bus_rsp_t inst_rsp_i,
	output cpu_pkg::bus_req_t data_req_o,
	input  cpu_pkg::bus_rsp_t data_rsp_i,
	input  logic              pause_i
);
	import cpu_pkg::*;

	logic                  interlock;

	logic [31:0]           if_instr;
	logic [XLEN-1:0]       if_pc;
	logic                  if_valid;

	logic [REG_ADDR_W-1:0] rs_addr;
	logic [REG_ADDR_W-1:0] rt_addr;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;

	id_ex_t                id_ex;
	ex_mem_t               ex_mem;
	wb_t                   wb;

	logic                  redirect;
	logic [XLEN-1:0]       target;

	// any bus still waiting holds every stage
	assign interlock = (inst_req_o.stb & ~inst_rsp_i.ack)
		| (data_req_o.stb & ~data_rsp_i.ack)
		| pause_i;

	cpu_fetch i_cpu_fetch (
		.clk        (clk),
		.reset      (reset),
		.stall_i    (interlock),
		.inst_req_o (inst_req_o),
		.inst_rsp_i (inst_rsp_i),
		.redirect_i (redirect),
		.target_i   (target),
		.instr_o    (if_instr),
		.pc_o       (if_pc),
		.valid_o    (if_valid)
	);

	cpu_decode i_cpu_decode (
		.clk       (clk),
		.reset     (reset),
		.stall_i   (interlock),
		.instr_i   (if_instr),
		.pc_i      (if_pc),
		.valid_i   (if_valid),
		.rs_data_i (rs_data),
		.rt_data_i (rt_data),
		.rs_addr_o (rs_addr),
		.rt_addr_o (rt_addr),
		.id_ex_o   (id_ex)
	);

	cpu_gpr i_cpu_gpr (
		.clk       (clk),
		.rs_addr_i (rs_addr),
		.rt_addr_i (rt_addr),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data),
		.wb_i      (wb),
		.stall_i   (interlock)
	);

	cpu_execute i_cpu_execute (
		.clk        (clk),
		.reset      (reset),
		.stall_i    (interlock),
		.id_ex_i    (id_ex),
		.mem_fwd_i  (wb),
		.ex_mem_o   (ex_mem),
		.redirect_o (redirect),
		.target_o   (target)
	);

	cpu_mem_stage i_cpu_mem_stage (
		.clk        (clk),
		.reset      (reset),
		.stall_i    (interlock),
		.ex_mem_i   (ex_mem),
		.data_req_o (data_req_o),
		.data_rsp_i (data_rsp_i),
		.wb_o       (wb)
	);

endmodule

/* verification/cpu_core_asserts.sv */
// -------------------------------------------------
// bus protocol checks, bound into cpu_core
// a request held without ack must stay unchanged
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_core_asserts (
	input logic              clk,
	input logic              reset,
	input cpu_pkg::bus_req_t inst_req_o,
	input cpu_pkg::bus_rsp_t inst_rsp_i,
	input cpu_pkg::bus_req_t data_req_o,
	input cpu_pkg::bus_rsp_t data_rsp_i
);
	logic fetched_q;
	int   fail_cnt = 0;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			fetched_q <= 1'b0;
		else if (inst_req_o.stb && inst_rsp_i.ack)
			fetched_q <= 1'b1;
	end

	// no data access before the first instruction arrives
	no_early_data: assert property (@(posedge clk) !fetched_q |-> !data_req_o.stb)
		else begin
			$error("data strobe raised before the first fetch acknowledge");
			fail_cnt++;
		end

	inst_stable: assert property (@(posedge clk) disable iff (reset)
		inst_req_o.stb && !inst_rsp_i.ack |=> inst_req_o.stb && $stable(inst_req_o.adr))
		else begin
			$error("instruction request changed before acknowledge");
			fail_cnt++;
		end

	data_stable: assert property (@(posedge clk) disable iff (reset)
		data_req_o.stb && !data_rsp_i.ack |=> data_req_o.stb && $stable(data_req_o.adr)
		&& $stable(data_req_o.we) && $stable(data_req_o.wdata))
		else begin
			$error("data request changed before acknowledge");
			fail_cnt++;
		end

endmodule

bind cpu_core cpu_core_asserts i_cpu_core_asserts (.*);

/* verification/cpu_checker.sv */
// -------------------------------------------------
// architectural model of the program and the
// store stream comparison on the data bus
// programs must stop on a self-jump within 400 steps
// -------------------------------------------------

`timescale 1ns/1ps

module cpu_checker (
	input logic              clk,
	input logic              reset,
	input cpu_pkg::bus_req_t data_req_i,
	input cpu_pkg::bus_rsp_t data_rsp_i,
	input logic [31:0]       prog_i [0:255]
);
	import cpu_pkg::*;

	logic [29:0] exp_adr [$];
	logic [31:0] exp_data [$];
	int          seen = 0;
	int          errors = 0;
	int          checks = 0;

	// data memory contents before any store
	function automatic logic [31:0] fill_word(input logic [29:0] widx);
		return {widx[15:0] ^ 16'h6932, ~widx[15:0]} ^ {2'b00, widx};
	endfunction

	function automatic int run_reference();
		logic [31:0] r [0:31];
		logic [31:0] mem [logic [29:0]];
		logic [31:0] pc, npc, nxt, ins, sext, zext, a, jt, rsv, rtv;
		logic [4:0]  rt, rd;
		int          i, n;
		exp_adr.delete();
		exp_data.delete();
		for (i = 0; i < 32; i++)
			r[i] = '0;
		pc  = RESET_PC;
		npc = pc + 32'd4;
		for (n = 0; n < 400; n++) begin
			ins  = prog_i[pc[9:2]];
			sext = {{16{ins[15]}}, ins[15:0]};
			zext = {16'h0000, ins[15:0]};
			rsv  = r[ins[25:21]];
			rtv  = r[ins[20:16]];
			rt   = ins[20:16];
			rd   = ins[15:11];
			a    = rsv + sext;
			nxt  = npc + 32'd4;
			jt   = {npc[31:28], ins[25:0], 2'b00};
			case (opcode_e'(ins[31:26]))
				OP_SPECIAL: begin
					case (funct_e'(ins[5:0]))
						FN_ADDU: r[rd] = rsv + rtv;
						FN_SUBU: r[rd] = rsv - rtv;
						FN_AND:  r[rd] = rsv & rtv;
						FN_OR:   r[rd] = rsv | rtv;
						FN_XOR:  r[rd] = rsv ^ rtv;
						FN_SLT:  r[rd] = ($signed(rsv) < $signed(rtv)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
				OP_ADDIU: r[rt] = rsv + sext;
				OP_ORI:   r[rt] = rsv | zext;
				OP_LUI:   r[rt] = {ins[15:0], 16'h0000};
				OP_LW:    r[rt] = mem.exists(a[31:2]) ? mem[a[31:2]] : fill_word(a[31:2]);
				OP_SW: begin
					mem[a[31:2]] = rtv;
					exp_adr.push_back(a[31:2]);
					exp_data.push_back(rtv);
				end
				OP_BEQ: if (rsv == rtv) nxt = npc + {sext[29:0], 2'b00};
				OP_BNE: if (rsv != rtv) nxt = npc + {sext[29:0], 2'b00};
				OP_J: begin
					// self-jump ends the program
					if (jt == pc)
						break;
					nxt = jt;
				end
				default: ;
			endcase
			r[0] = '0;
			pc   = npc;
			npc  = nxt;
		end
		seen = 0;
		return exp_adr.size();
	endfunction

	// ---------------------------------------------------
	// compare every acknowledged write
	// ---------------------------------------------------
	always @(posedge clk) begin
		if (!reset && data_req_i.stb && data_req_i.we && data_rsp_i.ack) begin
			if (seen >= exp_adr.size()) begin
				$display("%0t: store to word address %h that the program never makes",
					$time, data_req_i.adr);
				errors++;
			end else begin
				checks++;
				if (data_req_i.adr !== exp_adr[seen]) begin
					$display("mismatch at %0t: data_req_o.adr got %h expected %h",
						$time, data_req_i.adr, exp_adr[seen]);
					errors++;
				end
				if (data_req_i.wdata !== exp_data[seen]) begin
					$display("mismatch at %0t: data_req_o.wdata got %h expected %h",
						$time, data_req_i.wdata, exp_data[seen]);
					errors++;
				end
			end
			seen++;
		end
	end

endmodule

/* verification/tb_cpu_core.sv */
// -------------------------------------------------
// testbench: memory models with 0 to 3 wait states,
// four programs, each ending on a self-jump
// test 5 reruns the branch program with random pause
// -------------------------------------------------

`timescale 1ns/1ps

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int    N_TESTS     = 5;
	localparam real   WATCHDOG_NS = N_TESTS * 400 * 4 * 100.0;

	logic              clk = 1'b0;
	logic              reset;
	logic              pause_i;
	bus_req_t          inst_req, data_req;
	bus_rsp_t          inst_rsp, data_rsp;
	logic [31:0]       imem [0:255];
	logic [31:0]       dmem [0:1023];
	integer            seed = 32'h6932_6a95;
	int                inst_cnt, data_cnt, pos, n_exp, failed, errs_before;
	logic              pause_on;

	always #50 clk = ~clk;

	cpu_core i_cpu_core (
		.clk        (clk),
		.reset      (reset),
		.inst_req_o (inst_req),
		.inst_rsp_i (inst_rsp),
		.data_req_o (data_req),
		.data_rsp_i (data_rsp),
		.pause_i    (pause_i)
	);

	cpu_checker i_cpu_checker (
		.clk        (clk),
		.reset      (reset),
		.data_req_i (data_req),
		.data_rsp_i (data_rsp),
		.prog_i     (imem)
	);

	function automatic logic [31:0] rtype(funct_e fn, logic [4:0] rd, logic [4:0] rs,
		logic [4:0] rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] itype(opcode_e op, logic [4:0] rt, logic [4:0] rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// store mismatches plus bus protocol failures
	function automatic int total_errors();
		return i_cpu_checker.errors + i_cpu_core.i_cpu_core_asserts.fail_cnt;
	endfunction

	task automatic put(input logic [31:0] w);
		imem[pos] = w;
		pos++;
	endtask

	task automatic load_program(input int prog);
		int k;
		for (k = 0; k < 256; k++)
			imem[k] = '0;
		for (k = 0; k < 1024; k++)
			dmem[k] = i_cpu_checker.fill_word(30'(k));
		pos = 0;
		case (prog)
			1: begin
				put(itype(OP_ADDIU, 1, 0, 16'd100));
				put(itype(OP_ADDIU, 2, 0, 16'hfff9));
				put(itype(OP_ORI, 3, 0, 16'hf0f0));
				put(itype(OP_LUI, 4, 0, 16'h1234));
				put(rtype(FN_ADDU, 5, 1, 2));
				put(rtype(FN_SUBU, 6, 2, 1));
				put(rtype(FN_AND, 7, 3, 1));
				put(rtype(FN_OR, 8, 3, 2));
				put(rtype(FN_XOR, 9, 4, 3));
				put(rtype(FN_SLT, 10, 2, 1));
				put(rtype(FN_SLT, 11, 1, 2));
				for (k = 1; k < 12; k++)
					put(itype(OP_SW, 5'(k), 0, 16'(16'h0100 + 4 * k)));
			end
			2: begin
				put(itype(OP_ADDIU, 1, 0, 16'd5));
				put(rtype(FN_ADDU, 2, 1, 1));
				put(rtype(FN_ADDU, 3, 2, 1));
				put(rtype(FN_SUBU, 4, 3, 2));
				put(itype(OP_SW, 4, 0, 16'h0200));
				put(itype(OP_SW, 3, 0, 16'h0204));
				put(rtype(FN_XOR, 5, 4, 3));
				put(itype(OP_SW, 5, 0, 16'h0208));
			end
			3: begin
				put(itype(OP_ADDIU, 1, 0, 16'h0300));
				put(itype(OP_LUI, 2, 0, 16'hdead));
				put(itype(OP_ORI, 2, 2, 16'hbeef));
				put(itype(OP_SW, 2, 1, 16'd0));
				put(itype(OP_LW, 3, 1, 16'd0));
				// load delay slot
				put(32'h0000_0000);
				put(itype(OP_ADDIU, 4, 3, 16'd1));
				put(itype(OP_SW, 4, 1, 16'd4));
				put(itype(OP_SW, 3, 1, 16'd8));
			end
			default: begin
				put(itype(OP_ADDIU, 1, 0, 16'd1));
				put(itype(OP_ADDIU, 2, 0, 16'd1));
				put(itype(OP_ADDIU, 9, 0, 16'd0));
				put(itype(OP_BEQ, 2, 1, 16'd2));
				put(itype(OP_ADDIU, 9, 9, 16'd1));
				put(itype(OP_ADDIU, 9, 9, 16'd100));
				put(itype(OP_SW, 9, 0, 16'h0400));
				put(itype(OP_BNE, 2, 1, 16'd1));
				put(itype(OP_ADDIU, 9, 9, 16'd2));
				put(itype(OP_ADDIU, 9, 9, 16'd4));
				put(itype(OP_SW, 9, 0, 16'h0404));
				put(itype(OP_BNE, 0, 1, 16'd2));
				put(itype(OP_ADDIU, 9, 9, 16'd8));
				put(itype(OP_ADDIU, 9, 9, 16'd200));
				put(itype(OP_SW, 9, 0, 16'h0408));
				put(itype(OP_BEQ, 0, 1, 16'd1));
				put(itype(OP_ADDIU, 9, 9, 16'd16));
				put(itype(OP_ADDIU, 9, 9, 16'd32));
				put(itype(OP_SW, 9, 0, 16'h040c));
				put({OP_J, 26'(pos + 3)});
				put(itype(OP_ADDIU, 9, 9, 16'd64));
				put(itype(OP_ADDIU, 9, 9, 16'd300));
				put(itype(OP_SW, 9, 0, 16'h0410));
			end
		endcase
		// spin on a self-jump with a no-op delay slot
		put({OP_J, 26'(pos)});
		put(32'h0000_0000);
	endtask

	// ---------------------------------------------------
	// memory models, driven on the falling edge
	// ---------------------------------------------------
	always @(negedge clk) begin
		if (inst_rsp.ack || reset || !inst_req.stb)
			inst_cnt = -1;
		inst_rsp.ack = 1'b0;
		if (!reset && inst_req.stb) begin
			if (inst_cnt < 0)
				inst_cnt = $unsigned($random(seed)) % 4;
			if (inst_cnt == 0) begin
				inst_rsp.ack   = 1'b1;
				inst_rsp.rdata = imem[inst_req.adr[7:0]];
			end else begin
				inst_cnt--;
			end
		end
		if (data_rsp.ack || reset || !data_req.stb)
			data_cnt = -1;
		data_rsp.ack = 1'b0;
		if (!reset && data_req.stb) begin
			if (data_cnt < 0)
				data_cnt = $unsigned($random(seed)) % 4;
			if (data_cnt == 0) begin
				data_rsp.ack   = 1'b1;
				data_rsp.rdata = dmem[data_req.adr[9:0]];
				if (data_req.we)
					dmem[data_req.adr[9:0]] = data_req.wdata;
			end else begin
				data_cnt--;
			end
		end
		pause_i = pause_on && ($unsigned($random(seed)) % 3 == 0);
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the programs did not finish their stores in time");
		$display("Errors found");
		$finish;
	end

	initial begin
		reset    = 1'b1;
		pause_i  = 1'b0;
		pause_on = 1'b0;
		inst_rsp = '0;
		data_rsp = '0;
		failed   = 0;
		for (int t = 1; t <= N_TESTS; t++) begin
			@(negedge clk);
			reset    = 1'b1;
			pause_on = (t == 5);
			load_program(t == 5 ? 4 : t);
			repeat (10) @(negedge clk);
			// program memory has settled on the checker port by now
			n_exp       = i_cpu_checker.run_reference();
			errs_before = total_errors();
			reset       = 1'b0;
			while (i_cpu_checker.seen < n_exp)
				@(negedge clk);
			// room for any stray store after the last one
			repeat (20) @(negedge clk);
			pause_on = 1'b0;
			if (total_errors() != errs_before || n_exp == 0)
				failed++;
			$display("test %0d finished: %0d stores, %0s", t, n_exp,
				(total_errors() != errs_before || n_exp == 0) ? "FAIL" : "ok");
		end
		$display("tests %0d, failed %0d, store checks %0d, errors %0d", N_TESTS, failed,
			i_cpu_checker.checks, total_errors());
		if (failed == 0 && total_errors() == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* project.f */
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_gpr.sv
hw/cpu_execute.sv
hw/cpu_mem_stage.sv
hw/cpu_core.sv
verification/cpu_core_asserts.sv
verification/cpu_checker.sv
verification/tb_cpu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir -o sim_tb \
	--top-module tb_cpu_core -f project.f

./obj_dir/sim_tb | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
